// File: build.f
+incdir+source
source/ccu_pkg.sv
source/ccu_ctrl.sv
source/snoop_req_unit.sv
source/snoop_resp_collector.sv
source/snoop_data_buffer.sv
source/ccu_top.sv
test/tb_ccu.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_ccu -o tb_ccu || exit 1
./obj_dir/tb_ccu > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: test/tb_ccu.sv
`timescale 1ns/1ps
`include "ccu_macros.svh"

module tb_ccu;
    import ccu_pkg::*;

    localparam int NP = `CCU_NUM_PORTS;
    localparam int TXNS = 200;
    localparam int TXN_TIMEOUT = 1000;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic ar_valid_i, ar_ready_o;
    addr_t ar_addr_i;
    id_t ar_id_i;
    snoop_t ar_snoop_i;
    logic r_valid_o, r_last_o, r_ready_i;
    data_t r_data_o;
    id_t r_id_o;
    rresp_t r_resp_o;
    port_vec_t ac_valid_o, ac_ready_i, cr_valid_i, cr_ready_o;
    port_vec_t cd_valid_i, cd_last_i, cd_ready_o;
    addr_t ac_addr_o;
    snoop_t ac_snoop_o;
    cr_resp_t [NP-1:0] cr_resp_i;
    data_t [NP-1:0] cd_data_i;
    logic mem_ar_valid_o, mem_ar_ready_i;
    addr_t mem_ar_addr_o;
    id_t mem_ar_id_o;
    logic mem_r_valid_i, mem_r_last_i, mem_r_ready_o;
    data_t mem_r_data_i;
    logic [1:0] mem_r_resp_i;

    // request in flight and the one queued behind it
    addr_t cur_addr, nxt_addr;
    id_t cur_id, nxt_id;
    snoop_t cur_snoop, nxt_snoop;
    logic pending, accepted, exp_hit, exp_shared, exp_dirty, mem_req_seen;
    int init_port, exp_src, mem_cnt, r_cnt;
    cr_resp_t resp [NP];
    data_t snoop_line [NP][2];
    data_t mem_data [2];
    logic [1:0] mem_resp [2];
    int cr_wait [NP];
    int cd_cnt [NP];
    port_vec_t snooped, cr_done, sends_data;
    logic [31:0] lfsr = 32'hff51171c;

    ccu_top dut0 (.*);

    always #5 clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // random source and checks
    // ----------------------------------------------------------------------
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], rand_bit()};
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_id(input id_t got, input id_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_snoop(input snoop_t got, input snoop_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input rresp_t got, input rresp_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    function automatic logic outputs_quiet();
        return !(ar_ready_o || r_valid_o || mem_ar_valid_o || mem_r_ready_o
            || (|ac_valid_o) || (|cr_ready_o) || (|cd_ready_o));
    endfunction

    // ----------------------------------------------------------------------
    // stimulus and reference model
    // ----------------------------------------------------------------------
    task automatic issue_request();
        nxt_addr = addr_t'(rand_bits(32));
        nxt_id = id_t'(rand_bits(4));
        nxt_snoop = snoop_t'(rand_bits(4));
        ar_valid_i <= 1'b1;
        ar_addr_i <= nxt_addr;
        ar_id_i <= nxt_id;
        ar_snoop_i <= nxt_snoop;
        pending = 1'b1;
    endtask

    task automatic setup_txn();
        cur_addr = nxt_addr;
        cur_id = nxt_id;
        cur_snoop = nxt_snoop;
        pending = 1'b0;
        accepted = 1'b0;
        init_port = int'(cur_id[`CCU_ID_W-1 -: `CCU_PORT_IDX_W]);
        {exp_hit, exp_shared, exp_dirty, mem_req_seen} = '0;
        exp_src = 0;
        mem_cnt = 0;
        r_cnt = 0;
        snooped = '0;
        cr_done = '0;
        // walk down so the lowest usable port ends up as source
        for (int p = NP - 1; p >= 0; p--) begin
            resp[p] = cr_resp_t'(rand_bits(5));
            cr_wait[p] = int'(rand_bits(3));
            cd_cnt[p] = 0;
            snoop_line[p][0] = data_t'(rand_bits(64));
            snoop_line[p][1] = data_t'(rand_bits(64));
            if (p != init_port) begin
                exp_shared |= resp[p][`CR_SHARED_BIT];
                exp_dirty |= resp[p][`CR_DIRTY_BIT];
                if (resp[p][`CR_DATA_BIT] && !resp[p][`CR_ERROR_BIT]) begin
                    exp_hit = 1'b1;
                    exp_src = p;
                end
            end
        end
        // every data port sends its line once the hit is known
        for (int p = 0; p < NP; p++) begin
            sends_data[p] = exp_hit && p != init_port && resp[p][`CR_DATA_BIT];
        end
        for (int b = 0; b < 2; b++) begin
            mem_data[b] = data_t'(rand_bits(64));
            mem_resp[b] = 2'(rand_bits(2));
        end
    endtask

    task automatic handle_ar(input int t);
        if (ar_ready_o) begin
            if (!ar_valid_i) fail_run("ar_ready_o high without a request");
            if (accepted) fail_run("new request accepted before the previous one finished");
            accepted = 1'b1;
            ar_valid_i <= 1'b0;
        end else if (accepted && !pending && t < TXNS - 1 && rand_bits(4) == 0) begin
            // next request waits while this one is busy
            issue_request();
        end
    endtask

    task automatic handle_ports();
        for (int p = 0; p < NP; p++) begin
            if (ac_valid_o[p] && (p == init_port || snooped[p])) begin
                fail_run($sformatf("port %0d got a snoop it must not get", p));
            end
            if (ac_valid_o[p] && ac_ready_i[p]) begin
                check_addr(ac_addr_o, cur_addr, "ac_addr_o");
                check_snoop(ac_snoop_o, cur_snoop, "ac_snoop_o");
                snooped[p] = 1'b1;
            end
            ac_ready_i[p] <= rand_bit();
            // snoop response after a random delay
            if (cr_valid_i[p] && cr_ready_o[p]) begin
                cr_done[p] = 1'b1;
                cr_valid_i[p] <= 1'b0;
            end else if (snooped[p] && !cr_done[p] && !cr_valid_i[p]) begin
                if (cr_wait[p] == 0) begin
                    cr_valid_i[p] <= 1'b1;
                    cr_resp_i[p] <= resp[p];
                end else begin
                    cr_wait[p]--;
                end
            end
            // line beats with random gaps, held while stalled
            if (cd_valid_i[p] && cd_ready_o[p]) begin
                cd_cnt[p]++;
            end
            if (!cd_valid_i[p] || cd_ready_o[p]) begin
                if (sends_data[p] && cr_done[p] && cd_cnt[p] < 2 && rand_bit()) begin
                    cd_valid_i[p] <= 1'b1;
                    cd_data_i[p] <= snoop_line[p][cd_cnt[p]];
                    cd_last_i[p] <= (cd_cnt[p] == 1);
                end else begin
                    cd_valid_i[p] <= 1'b0;
                end
            end
        end
    endtask

    task automatic handle_memory();
        if (mem_ar_valid_o && mem_ar_ready_i) begin
            if (exp_hit || mem_req_seen) fail_run("memory got a read request it should not get");
            check_addr(mem_ar_addr_o, cur_addr, "mem_ar_addr_o");
            check_id(mem_ar_id_o, cur_id, "mem_ar_id_o");
            mem_req_seen = 1'b1;
        end
        mem_ar_ready_i <= rand_bit();
        if (mem_r_valid_i) begin
            check_flag(mem_r_ready_o, r_ready_i, "mem_r_ready_o");
        end
        if (mem_r_valid_i && mem_r_ready_o) begin
            mem_cnt++;
        end
        if (!mem_r_valid_i || mem_r_ready_o) begin
            if (mem_req_seen && mem_cnt < 2 && rand_bit()) begin
                mem_r_valid_i <= 1'b1;
                mem_r_data_i <= mem_data[mem_cnt];
                mem_r_resp_i <= mem_resp[mem_cnt];
                mem_r_last_i <= (mem_cnt == 1);
            end else begin
                mem_r_valid_i <= 1'b0;
            end
        end
    endtask

    task automatic handle_read();
        if (r_valid_o && r_ready_i) begin
            if (r_cnt >= 2 || (!exp_hit && !mem_req_seen)) fail_run("unexpected read data beat");
            if (exp_hit) begin
                check_data(r_data_o, snoop_line[exp_src][r_cnt], "r_data_o");
                check_resp(r_resp_o, {exp_shared, exp_dirty, 2'b00}, "r_resp_o");
            end else begin
                check_data(r_data_o, mem_data[r_cnt], "r_data_o");
                check_resp(r_resp_o, {2'b00, mem_resp[r_cnt]}, "r_resp_o");
            end
            check_id(r_id_o, cur_id, "r_id_o");
            check_flag(r_last_o, r_cnt == 1, "r_last_o");
            r_cnt++;
        end
        r_ready_i <= (rand_bits(2) != 0);
    endtask

    function automatic logic txn_done();
        logic ports_done;
        ports_done = 1'b1;
        for (int p = 0; p < NP; p++) begin
            if (p != init_port && !cr_done[p]) ports_done = 1'b0;
            if (sends_data[p] && cd_cnt[p] != 2) ports_done = 1'b0;
        end
        return ports_done && r_cnt == 2;
    endfunction

    task automatic run_txn(input int t);
        int cycles;
        if (!pending) issue_request();
        setup_txn();
        cycles = 0;
        while (!txn_done()) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > TXN_TIMEOUT) fail_run($sformatf("transaction %0d never finished", t));
            handle_ar(t);
            handle_ports();
            handle_memory();
            handle_read();
        end
    endtask

    initial begin
        rst_ni <= 1'b0;
        ar_valid_i <= 1'b0;
        ar_addr_i <= '0;
        ar_id_i <= '0;
        ar_snoop_i <= '0;
        r_ready_i <= 1'b0;
        ac_ready_i <= '0;
        cr_valid_i <= '0;
        cr_resp_i <= '0;
        cd_valid_i <= '0;
        cd_data_i <= '0;
        cd_last_i <= '0;
        mem_ar_ready_i <= 1'b0;
        mem_r_valid_i <= 1'b0;
        mem_r_data_i <= '0;
        mem_r_resp_i <= '0;
        mem_r_last_i <= 1'b0;
        pending = 1'b0;
        // first edge applies the reset
        for (int c = 0; c < 5; c++) begin
            @(posedge clk_i);
            if (c > 0 && !outputs_quiet()) fail_run("a valid or ready output is high in reset");
        end
        rst_ni <= 1'b1;
        @(posedge clk_i);
        if (!outputs_quiet()) fail_run("a valid or ready output is high after reset");
        for (int t = 0; t < TXNS; t++) begin
            run_txn(t);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// File: source/ccu_top.sv
`timescale 1ns/1ps
`include "ccu_macros.svh"

module ccu_top (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    // initiator read address
    input  logic                                      ar_valid_i,
    input  ccu_pkg::addr_t                            ar_addr_i,
    input  ccu_pkg::id_t                              ar_id_i,
    input  ccu_pkg::snoop_t                           ar_snoop_i,
    output logic                                      ar_ready_o,
    // initiator read data
    output logic                                      r_valid_o,
    output ccu_pkg::data_t                            r_data_o,
    output ccu_pkg::id_t                              r_id_o,
    output ccu_pkg::rresp_t                           r_resp_o,
    output logic                                      r_last_o,
    input  logic                                      r_ready_i,
    // snoop address
    output ccu_pkg::port_vec_t                        ac_valid_o,
    output ccu_pkg::addr_t                            ac_addr_o,
    output ccu_pkg::snoop_t                           ac_snoop_o,
    input  ccu_pkg::port_vec_t                        ac_ready_i,
    // snoop response
    input  ccu_pkg::port_vec_t                        cr_valid_i,
    input  ccu_pkg::cr_resp_t [`CCU_NUM_PORTS-1:0]    cr_resp_i,
    output ccu_pkg::port_vec_t                        cr_ready_o,
    // snoop data
    input  ccu_pkg::port_vec_t                        cd_valid_i,
    input  ccu_pkg::data_t [`CCU_NUM_PORTS-1:0]       cd_data_i,
    input  ccu_pkg::port_vec_t                        cd_last_i,
    output ccu_pkg::port_vec_t                        cd_ready_o,
    // memory read address
    output logic                                      mem_ar_valid_o,
    output ccu_pkg::addr_t                            mem_ar_addr_o,
    output ccu_pkg::id_t                              mem_ar_id_o,
    input  logic                                      mem_ar_ready_i,
    // memory read data
    input  logic                                      mem_r_valid_i,
    input  ccu_pkg::data_t                            mem_r_data_i,
    input  logic [1:0]                                mem_r_resp_i,
    input  logic                                      mem_r_last_i,
    output logic                                      mem_r_ready_o
);
    import ccu_pkg::*;

    logic snoop_start, data_phase, line_done;
    logic all_acked, all_resp, snoop_hit, shared, dirty;
    port_vec_t initiator_mask, data_mask;
    port_idx_t first_idx;
    addr_t held_addr;
    id_t held_id;
    snoop_t held_snoop;

    // read data from the memory path and from the snoop line buffer
    logic ctrl_r_valid, ctrl_r_last, buf_r_valid, buf_r_last;
    data_t ctrl_r_data, buf_r_data;
    rresp_t ctrl_r_resp, buf_r_resp;

    ccu_ctrl ctrl0 (
        .clk_i, .rst_ni,
        .ar_valid_i, .ar_addr_i, .ar_id_i, .ar_snoop_i, .ar_ready_o,
        .all_acked_i(all_acked), .all_resp_i(all_resp),
        .snoop_hit_i(snoop_hit), .line_done_i(line_done),
        .snoop_start_o(snoop_start), .initiator_mask_o(initiator_mask),
        .data_phase_o(data_phase),
        .held_addr_o(held_addr), .held_id_o(held_id), .held_snoop_o(held_snoop),
        .mem_ar_valid_o, .mem_ar_addr_o, .mem_ar_id_o, .mem_ar_ready_i,
        .mem_r_valid_i, .mem_r_data_i, .mem_r_resp_i, .mem_r_last_i, .mem_r_ready_o,
        .r_valid_o(ctrl_r_valid), .r_data_o(ctrl_r_data),
        .r_resp_o(ctrl_r_resp), .r_last_o(ctrl_r_last), .r_ready_i
    );

    snoop_req_unit req0 (
        .clk_i, .rst_ni,
        .snoop_start_i(snoop_start), .initiator_mask_i(initiator_mask),
        .held_addr_i(held_addr), .held_snoop_i(held_snoop),
        .ac_valid_o, .ac_addr_o, .ac_snoop_o, .ac_ready_i,
        .all_acked_o(all_acked)
    );

    snoop_resp_collector resp0 (
        .clk_i, .rst_ni,
        .snoop_start_i(snoop_start), .initiator_mask_i(initiator_mask),
        .cr_valid_i, .cr_resp_i, .cr_ready_o,
        .all_resp_o(all_resp), .snoop_hit_o(snoop_hit), .data_mask_o(data_mask),
        .first_idx_o(first_idx), .shared_o(shared), .dirty_o(dirty)
    );

    // held id reaches the initiator through the buffer on both paths
    snoop_data_buffer buf0 (
        .clk_i, .rst_ni,
        .data_phase_i(data_phase), .data_mask_i(data_mask), .first_idx_i(first_idx),
        .shared_i(shared), .dirty_i(dirty), .held_id_i(held_id),
        .cd_valid_i, .cd_data_i, .cd_last_i, .cd_ready_o,
        .r_valid_o(buf_r_valid), .r_data_o(buf_r_data), .r_id_o,
        .r_resp_o(buf_r_resp), .r_last_o(buf_r_last), .r_ready_i,
        .line_done_o(line_done)
    );

    // the line buffer owns the read channel during the snoop data phase
    assign r_valid_o = data_phase ? buf_r_valid : ctrl_r_valid;
    assign r_data_o  = data_phase ? buf_r_data  : ctrl_r_data;
    assign r_resp_o  = data_phase ? buf_r_resp  : ctrl_r_resp;
    assign r_last_o  = data_phase ? buf_r_last  : ctrl_r_last;

endmodule

// File: source/snoop_data_buffer.sv
`timescale 1ns/1ps
`include "ccu_macros.svh"

module snoop_data_buffer (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 data_phase_i,
    input  ccu_pkg::port_vec_t                   data_mask_i,
    input  ccu_pkg::port_idx_t                   first_idx_i,
    input  logic                                 shared_i,
    input  logic                                 dirty_i,
    input  ccu_pkg::id_t                         held_id_i,
    input  ccu_pkg::port_vec_t                   cd_valid_i,
    input  ccu_pkg::data_t [`CCU_NUM_PORTS-1:0]  cd_data_i,
    input  ccu_pkg::port_vec_t                   cd_last_i,
    output ccu_pkg::port_vec_t                   cd_ready_o,
    output logic                                 r_valid_o,
    output ccu_pkg::data_t                       r_data_o,
    output ccu_pkg::id_t                         r_id_o,
    output ccu_pkg::rresp_t                      r_resp_o,
    output logic                                 r_last_o,
    input  logic                                 r_ready_i,
    output logic                                 line_done_o
);
    import ccu_pkg::*;

    localparam int unsigned PTR_W = $clog2(`CCU_LINE_BEATS);

    data_t buf_mem [`CCU_LINE_BEATS];
    logic [PTR_W-1:0] wr_ptr_q, beat_q;
    logic [1:0] count_q;
    logic r_done_q;
    port_vec_t cd_done_q, cd_hs;
    logic fwd_hs, r_hs;

    // ------------------------------------------------------------------
    // snoop data intake
    // ------------------------------------------------------------------
    // other data ports keep draining, their beats are dropped
    always_comb begin
        for (int i = 0; i < `CCU_NUM_PORTS; i++) begin
            cd_ready_o[i] = data_phase_i & data_mask_i[i] & ~cd_done_q[i];
        end
        if (count_q == 2'd2) begin
            cd_ready_o[first_idx_i] = 1'b0;
        end
    end

    assign cd_hs  = cd_valid_i & cd_ready_o;
    assign fwd_hs = cd_hs[first_idx_i];
    assign r_hs   = r_valid_o && r_ready_i;

    always_ff @(posedge clk_i) begin
        if (fwd_hs) begin
            buf_mem[wr_ptr_q] <= cd_data_i[first_idx_i];
        end
    end

    // cleared between transactions
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q  <= '0;
            beat_q    <= '0;
            count_q   <= '0;
            r_done_q  <= 1'b0;
            cd_done_q <= '0;
        end else if (!data_phase_i) begin
            wr_ptr_q  <= '0;
            beat_q    <= '0;
            count_q   <= '0;
            r_done_q  <= 1'b0;
            cd_done_q <= '0;
        end else begin
            cd_done_q <= cd_done_q | (cd_hs & cd_last_i);
            count_q   <= count_q + 2'(fwd_hs) - 2'(r_hs);
            if (fwd_hs) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (r_hs) begin
                beat_q <= beat_q + 1'b1;
                if (r_last_o) begin
                    r_done_q <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // initiator read channel
    // ------------------------------------------------------------------
    assign r_valid_o = data_phase_i && (count_q != 2'd0);
    assign r_data_o  = buf_mem[beat_q];
    assign r_id_o    = held_id_i;
    assign r_resp_o  = {shared_i, dirty_i, 2'b00};
    assign r_last_o  = (beat_q == PTR_W'(`CCU_LINE_BEATS - 1));

    // every data port finished and the last beat taken by the initiator
    assign line_done_o = data_phase_i
        && (((cd_done_q | (cd_hs & cd_last_i)) & data_mask_i) == data_mask_i)
        && (r_done_q || (r_hs && r_last_o));

    a_fill_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= 2'd2);

    a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o));

endmodule

// File: source/snoop_resp_collector.sv
`timescale 1ns/1ps
`include "ccu_macros.svh"

module snoop_resp_collector (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    snoop_start_i,
    input  ccu_pkg::port_vec_t                      initiator_mask_i,
    input  ccu_pkg::port_vec_t                      cr_valid_i,
    input  ccu_pkg::cr_resp_t [`CCU_NUM_PORTS-1:0]  cr_resp_i,
    output ccu_pkg::port_vec_t                      cr_ready_o,
    output logic                                    all_resp_o,
    output logic                                    snoop_hit_o,
    output ccu_pkg::port_vec_t                      data_mask_o,
    output ccu_pkg::port_idx_t                      first_idx_o,
    output logic                                    shared_o,
    output logic                                    dirty_o
);
    import ccu_pkg::*;

    port_vec_t responded_q, data_q, error_q, dirty_q, shared_q;
    port_vec_t hit_mask;

    // idle with every port marked as responded, so no ready is raised
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            responded_q <= '1;
            data_q      <= '0;
            error_q     <= '0;
            dirty_q     <= '0;
            shared_q    <= '0;
        end else if (snoop_start_i) begin
            responded_q <= initiator_mask_i;
            data_q      <= '0;
            error_q     <= '0;
            dirty_q     <= '0;
            shared_q    <= '0;
        end else begin
            for (int i = 0; i < `CCU_NUM_PORTS; i++) begin
                if (cr_valid_i[i] && cr_ready_o[i]) begin
                    responded_q[i] <= 1'b1;
                    data_q[i]      <= cr_resp_i[i][`CR_DATA_BIT];
                    error_q[i]     <= cr_resp_i[i][`CR_ERROR_BIT];
                    dirty_q[i]     <= cr_resp_i[i][`CR_DIRTY_BIT];
                    shared_q[i]    <= cr_resp_i[i][`CR_SHARED_BIT];
                end
            end
        end
    end

    assign cr_ready_o = ~responded_q;
    assign all_resp_o = &responded_q;

    // usable data means data without error
    assign hit_mask    = data_q & ~error_q;
    assign snoop_hit_o = |hit_mask;
    assign data_mask_o = data_q;
    assign shared_o    = |shared_q;
    assign dirty_o     = |dirty_q;

    // lowest index wins
    always_comb begin
        first_idx_o = '0;
        for (int i = `CCU_NUM_PORTS - 1; i >= 0; i--) begin
            if (hit_mask[i]) begin
                first_idx_o = port_idx_t'(i);
            end
        end
    end

endmodule

// File: source/snoop_req_unit.sv
`timescale 1ns/1ps
`include "ccu_macros.svh"

module snoop_req_unit (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 snoop_start_i,
    input  ccu_pkg::port_vec_t   initiator_mask_i,
    input  ccu_pkg::addr_t       held_addr_i,
    input  ccu_pkg::snoop_t      held_snoop_i,
    output ccu_pkg::port_vec_t   ac_valid_o,
    output ccu_pkg::addr_t       ac_addr_o,
    output ccu_pkg::snoop_t      ac_snoop_o,
    input  ccu_pkg::port_vec_t   ac_ready_i,
    output logic                 all_acked_o
);
    import ccu_pkg::*;

    logic active_q;
    port_vec_t acked_q;

    // the initiator counts as acked from the start
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            acked_q  <= '0;
        end else if (snoop_start_i) begin
            active_q <= 1'b1;
            acked_q  <= initiator_mask_i;
        end else if (active_q) begin
            if (&acked_q) begin
                active_q <= 1'b0;
            end
            acked_q <= acked_q | (ac_valid_o & ac_ready_i);
        end
    end

    assign ac_valid_o  = {`CCU_NUM_PORTS{active_q}} & ~acked_q;
    assign ac_addr_o   = held_addr_i;
    assign ac_snoop_o  = held_snoop_i;
    assign all_acked_o = active_q && (&acked_q);

endmodule

// File: source/ccu_ctrl.sv
`timescale 1ns/1ps
`include "ccu_macros.svh"

module ccu_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 ar_valid_i,
    input  ccu_pkg::addr_t       ar_addr_i,
    input  ccu_pkg::id_t         ar_id_i,
    input  ccu_pkg::snoop_t      ar_snoop_i,
    output logic                 ar_ready_o,
    input  logic                 all_acked_i,
    input  logic                 all_resp_i,
    input  logic                 snoop_hit_i,
    input  logic                 line_done_i,
    output logic                 snoop_start_o,
    output ccu_pkg::port_vec_t   initiator_mask_o,
    output logic                 data_phase_o,
    output ccu_pkg::addr_t       held_addr_o,
    output ccu_pkg::id_t         held_id_o,
    output ccu_pkg::snoop_t      held_snoop_o,
    output logic                 mem_ar_valid_o,
    output ccu_pkg::addr_t       mem_ar_addr_o,
    output ccu_pkg::id_t         mem_ar_id_o,
    input  logic                 mem_ar_ready_i,
    input  logic                 mem_r_valid_i,
    input  ccu_pkg::data_t       mem_r_data_i,
    input  logic [1:0]           mem_r_resp_i,
    input  logic                 mem_r_last_i,
    output logic                 mem_r_ready_o,
    output logic                 r_valid_o,
    output ccu_pkg::data_t       r_data_o,
    output ccu_pkg::rresp_t      r_resp_o,
    output logic                 r_last_o,
    input  logic                 r_ready_i
);
    import ccu_pkg::*;

    ccu_state_e state_q, state_d;
    addr_t held_addr_q;
    id_t held_id_q;
    snoop_t held_snoop_q;

    // ------------------------------------------------------------------
    // request holding
    // ------------------------------------------------------------------
    // request payload captured while idle
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && ar_valid_i) begin
            held_addr_q  <= ar_addr_i;
            held_id_q    <= ar_id_i;
            held_snoop_q <= ar_snoop_i;
        end
    end

    assign held_addr_o  = held_addr_q;
    assign held_id_o    = held_id_q;
    assign held_snoop_o = held_snoop_q;

    // initiator port from the top id bits
    assign initiator_mask_o =
        port_vec_t'(1'b1) << held_id_q[`CCU_ID_W-1 -: `CCU_PORT_IDX_W];

    // ------------------------------------------------------------------
    // transaction FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (ar_valid_i) state_d = DECODE;
            DECODE:     state_d = SNOOP_REQ;
            SNOOP_REQ:  if (all_acked_i) state_d = SNOOP_RESP;
            SNOOP_RESP: begin
                if (all_resp_i) begin
                    state_d = snoop_hit_i ? SNOOP_DATA : MEM_REQ;
                end
            end
            SNOOP_DATA: if (line_done_i) state_d = IDLE;
            MEM_REQ:    if (mem_ar_ready_i) state_d = MEM_READ;
            MEM_READ: begin
                // last accepted memory beat closes the transaction
                if (mem_r_valid_i && r_ready_i && mem_r_last_i) begin
                    state_d = IDLE;
                end
            end
            default:    state_d = IDLE;
        endcase
    end

    assign ar_ready_o    = (state_q == DECODE);
    assign snoop_start_o = (state_q == DECODE);
    assign data_phase_o  = (state_q == SNOOP_DATA);

    // ------------------------------------------------------------------
    // memory read path
    // ------------------------------------------------------------------
    assign mem_ar_valid_o = (state_q == MEM_REQ);
    assign mem_ar_addr_o  = held_addr_q;
    assign mem_ar_id_o    = held_id_q;

    // beats pass straight through to the initiator
    assign mem_r_ready_o = (state_q == MEM_READ) && r_ready_i;
    assign r_valid_o     = (state_q == MEM_READ) && mem_r_valid_i;
    assign r_data_o      = mem_r_data_i;
    assign r_resp_o      = {2'b00, mem_r_resp_i};
    assign r_last_o      = mem_r_last_i;

    // the held request is the one being accepted
    a_ar_capture: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_ready_o |-> held_addr_q == ar_addr_i && held_id_q == ar_id_i
            && held_snoop_q == ar_snoop_i);

    a_mem_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o));

endmodule

// File: source/ccu_pkg.sv
`include "ccu_macros.svh"

package ccu_pkg;

    typedef logic [`CCU_ADDR_W-1:0] addr_t;
    typedef logic [`CCU_DATA_W-1:0] data_t;
    typedef logic [`CCU_ID_W-1:0] id_t;
    typedef logic [`CCU_SNOOP_W-1:0] snoop_t;

    // bit 4 is the was-unique flag
    typedef logic [`CCU_CR_W-1:0] cr_resp_t;

    typedef logic [`CCU_NUM_PORTS-1:0] port_vec_t;
    typedef logic [`CCU_PORT_IDX_W-1:0] port_idx_t;

    // shared, dirty, then the two memory status bits
    typedef logic [`CCU_RRESP_W-1:0] rresp_t;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        SNOOP_REQ,
        SNOOP_RESP,
        SNOOP_DATA,
        MEM_REQ,
        MEM_READ
    } ccu_state_e;

endpackage

// File: source/ccu_macros.svh
`ifndef CCU_MACROS_SVH
`define CCU_MACROS_SVH

// coherent ports, the port index sits in the top id bits
`define CCU_NUM_PORTS 4
`define CCU_PORT_IDX_W 2

// channel widths
`define CCU_ADDR_W 32
`define CCU_DATA_W 64
`define CCU_ID_W 4
`define CCU_SNOOP_W 4
`define CCU_CR_W 5
`define CCU_RRESP_W 4

// beats per cache line
`define CCU_LINE_BEATS 2

// snoop response bits
`define CR_DATA_BIT 0
`define CR_ERROR_BIT 1
`define CR_DIRTY_BIT 2
`define CR_SHARED_BIT 3

`endif
